// ==== hdl/ddr_req_pkg.sv ====
// shared widths, command codes and request structs; reads return BEATS_PER_READ beats each
package ddr_req_pkg;

    // *********************************************************************
    // widths and codes of the ddr2 fifo interface
    // *********************************************************************

    // command address width seen by the address fifo
    localparam int ADDR_W = 31;
    // one write-data or read-data beat
    localparam int DATA_W = 128;
    // one mask bit per data byte
    localparam int MASK_W = 16;
    localparam int CMD_W  = 3;

    localparam logic [CMD_W-1:0] CMD_WRITE = 3'd0;
    localparam logic [CMD_W-1:0] CMD_READ  = 3'd1;

    // a set mask bit means the byte is not written
    localparam logic [MASK_W-1:0] MASK_NONE = '1;

    // every read command comes back as this many beats
    localparam int BEATS_PER_READ = 2;
    // beat index bits inside one read response
    localparam int BEAT_IDX_W = $clog2(BEATS_PER_READ);
    // counter wide enough to hold a full response
    localparam int BEAT_CNT_W = $clog2(BEATS_PER_READ + 1);

    // read sequence numbers are wider than any fifo depth so wrap is harmless
    localparam int REQ_NUM_W = 11;
    // upper bits of the returned beat count give the serviced read number
    localparam int SERVICED_W = REQ_NUM_W + BEAT_IDX_W;

    // *********************************************************************
    // client and fifo types
    // *********************************************************************

    // which client owns the fifos this cycle
    typedef enum logic [2:0] {
        GRANT_NONE,
        GRANT_ICACHE,
        GRANT_DCACHE,
        GRANT_PIXEL,
        GRANT_FILLER
    } grant_e;

    // full read/write client (icache, dcache)
    typedef struct packed {
        logic              cmd_en;
        logic [CMD_W-1:0]  cmd;
        logic [ADDR_W-1:0] addr;
        logic              wdf_en;
        logic [DATA_W-1:0] wdf_data;
        logic [MASK_W-1:0] wdf_mask;
    } cache_req_t;

    // read-only client (pixel feeder)
    typedef struct packed {
        logic              cmd_en;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    // write-only client (color filler)
    typedef struct packed {
        logic              cmd_en;
        logic [ADDR_W-1:0] addr;
        logic              wdf_en;
        logic [DATA_W-1:0] wdf_data;
        logic [MASK_W-1:0] wdf_mask;
    } wr_req_t;

    // what gets pushed into the address and write-data fifos
    typedef struct packed {
        logic              cmd_en;
        logic [CMD_W-1:0]  cmd;
        logic [ADDR_W-1:0] addr;
        logic              wdf_en;
        logic [DATA_W-1:0] wdf_data;
        logic [MASK_W-1:0] wdf_mask;
    } ddr_req_t;

    // fifo status and the flags each client is told
    typedef struct packed {
        logic cmd_full;
        logic wdf_full;
    } fifo_full_t;

endpackage

// ==== hdl/req_arbiter.sv ====
// fixed priority icache > dcache > pixel > filler; filler keeps the fifos for its second beat
`timescale 1ns/1ns

module req_arbiter
    import ddr_req_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cache_req_t i_icache_req,
    input  cache_req_t i_dcache_req,
    input  rd_req_t    i_pixel_req,
    input  wr_req_t    i_filler_req,
    input  fifo_full_t i_fifo_full,
    output ddr_req_t   o_ddr_req,
    output grant_e     o_grant,
    output fifo_full_t o_icache_full,
    output fifo_full_t o_dcache_full,
    output fifo_full_t o_pixel_full,
    output fifo_full_t o_filler_full
);

    // either fifo full blocks both, so command and data enter together
    logic fifo_busy;
    // set between the filler's first and second beat
    logic filler_reserved;
    logic icache_active;
    logic dcache_active;
    logic pixel_active;
    logic filler_active;

    assign fifo_busy     = i_fifo_full.cmd_full || i_fifo_full.wdf_full;
    assign icache_active = i_icache_req.cmd_en || i_icache_req.wdf_en;
    assign dcache_active = i_dcache_req.cmd_en || i_dcache_req.wdf_en;
    assign pixel_active  = i_pixel_req.cmd_en;
    assign filler_active = i_filler_req.cmd_en || i_filler_req.wdf_en;

    // *********************************************************************
    // grant selection
    // *********************************************************************

    always_comb begin
        // while reserved nobody but the filler may get in
        if (filler_reserved) begin
            o_grant = filler_active ? GRANT_FILLER : GRANT_NONE;
        end else if (icache_active) begin
            o_grant = GRANT_ICACHE;
        end else if (dcache_active) begin
            o_grant = GRANT_DCACHE;
        end else if (pixel_active) begin
            o_grant = GRANT_PIXEL;
        end else if (filler_active) begin
            o_grant = GRANT_FILLER;
        end else begin
            o_grant = GRANT_NONE;
        end
    end

    // toggles on each accepted filler beat, so two beats make one burst
    always_ff @(posedge clk) begin
        if (rst) begin
            filler_reserved <= 1'b0;
        end else if (o_grant == GRANT_FILLER && !fifo_busy) begin
            filler_reserved <= ~filler_reserved;
        end
    end

    // *********************************************************************
    // request mux onto the fifo inputs
    // *********************************************************************

    always_comb begin
        // idle default follows the icache fields with both enables low
        o_ddr_req.cmd_en   = 1'b0;
        o_ddr_req.cmd      = i_icache_req.cmd;
        o_ddr_req.addr     = i_icache_req.addr;
        o_ddr_req.wdf_en   = 1'b0;
        o_ddr_req.wdf_data = i_icache_req.wdf_data;
        o_ddr_req.wdf_mask = i_icache_req.wdf_mask;
        case (o_grant)
            GRANT_ICACHE: begin
                o_ddr_req.cmd_en = i_icache_req.cmd_en && !fifo_busy;
                o_ddr_req.wdf_en = i_icache_req.wdf_en && !fifo_busy;
            end
            GRANT_DCACHE: begin
                o_ddr_req.cmd_en   = i_dcache_req.cmd_en && !fifo_busy;
                o_ddr_req.cmd      = i_dcache_req.cmd;
                o_ddr_req.addr     = i_dcache_req.addr;
                o_ddr_req.wdf_en   = i_dcache_req.wdf_en && !fifo_busy;
                o_ddr_req.wdf_data = i_dcache_req.wdf_data;
                o_ddr_req.wdf_mask = i_dcache_req.wdf_mask;
            end
            GRANT_PIXEL: begin
                // read only, nothing goes to the write-data fifo
                o_ddr_req.cmd_en   = i_pixel_req.cmd_en && !fifo_busy;
                o_ddr_req.cmd      = CMD_READ;
                o_ddr_req.addr     = i_pixel_req.addr;
                o_ddr_req.wdf_data = '0;
                o_ddr_req.wdf_mask = MASK_NONE;
            end
            GRANT_FILLER: begin
                // write only
                o_ddr_req.cmd_en   = i_filler_req.cmd_en && !fifo_busy;
                o_ddr_req.cmd      = CMD_WRITE;
                o_ddr_req.addr     = i_filler_req.addr;
                o_ddr_req.wdf_en   = i_filler_req.wdf_en && !fifo_busy;
                o_ddr_req.wdf_data = i_filler_req.wdf_data;
                o_ddr_req.wdf_mask = i_filler_req.wdf_mask;
            end
            default: begin
            end
        endcase
    end

    // *********************************************************************
    // per-client full flags
    // *********************************************************************

    // losers always see full while the winner sees the real fifo state
    function automatic fifo_full_t full_for(input grant_e grant, input grant_e owner,
                                            input logic busy);
        fifo_full_t flags;
        flags.cmd_full = (grant != owner) || busy;
        flags.wdf_full = flags.cmd_full;
        return flags;
    endfunction

    assign o_icache_full = full_for(o_grant, GRANT_ICACHE, fifo_busy);
    assign o_dcache_full = full_for(o_grant, GRANT_DCACHE, fifo_busy);
    // pixel has no write path so its data flag mirrors the command flag
    assign o_pixel_full  = full_for(o_grant, GRANT_PIXEL, fifo_busy);
    assign o_filler_full = full_for(o_grant, GRANT_FILLER, fifo_busy);

endmodule

// ==== hdl/read_owner_tracker.sv ====
// one outstanding read per cache; the cache must not issue again before both beats return
`timescale 1ns/1ns

module read_owner_tracker
    import ddr_req_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // this cache's read command was just accepted
    input  logic                 i_issue,
    input  logic [REQ_NUM_W-1:0] i_issue_num,
    // read number currently coming back from ddr2
    input  logic [REQ_NUM_W-1:0] i_serviced_num,
    input  logic                 i_rdf_valid,
    output logic                 o_owner
);

    // sequence number of our outstanding read
    logic [REQ_NUM_W-1:0]  req_num;
    // beats still owed to this cache
    logic [BEAT_CNT_W-1:0] beats_left;

    // latch the number handed out to each accepted read
    always_ff @(posedge clk) begin
        if (i_issue) begin
            req_num <= i_issue_num;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
        end else if (i_issue) begin
            beats_left <= BEAT_CNT_W'(BEATS_PER_READ);
        end else if (o_owner && i_rdf_valid) begin
            // one returned beat consumed
            beats_left <= beats_left - BEAT_CNT_W'(1);
        end
    end

    // our turn once the serviced stream reaches our number
    assign o_owner = (beats_left != '0) && (req_num == i_serviced_num);

endmodule

// ==== hdl/read_return_router.sv ====
// caches hold at most one read each; read beats not owned by a cache go to the pixel feeder
`timescale 1ns/1ns

module read_return_router
    import ddr_req_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  grant_e   i_grant,
    input  ddr_req_t i_ddr_req,
    input  logic     i_rdf_valid,
    input  logic     i_icache_rd_en,
    input  logic     i_dcache_rd_en,
    input  logic     i_pixel_rd_en,
    output logic     o_rdf_rd_en,
    output logic     o_icache_rdf_valid,
    output logic     o_dcache_rdf_valid,
    output logic     o_pixel_rdf_valid
);

    // command enable is already gated by full, so this is an accepted read
    logic                  read_issued;
    // number the next accepted read will get
    logic [REQ_NUM_W-1:0]  issued_num;
    // every returned beat counts here
    logic [SERVICED_W-1:0] serviced_cnt;
    logic [REQ_NUM_W-1:0]  serviced_num;
    logic                  icache_owner;
    logic                  dcache_owner;

    assign read_issued  = i_ddr_req.cmd_en && (i_ddr_req.cmd == CMD_READ);
    // drop the beat index bits
    assign serviced_num = serviced_cnt[SERVICED_W-1 -: REQ_NUM_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            issued_num   <= '0;
            serviced_cnt <= '0;
        end else begin
            if (read_issued) begin
                issued_num <= issued_num + REQ_NUM_W'(1);
            end
            if (i_rdf_valid) begin
                serviced_cnt <= serviced_cnt + SERVICED_W'(1);
            end
        end
    end

    read_owner_tracker icache_tracker_inst (
        .clk            (clk),
        .rst            (rst),
        .i_issue        (read_issued && (i_grant == GRANT_ICACHE)),
        .i_issue_num    (issued_num),
        .i_serviced_num (serviced_num),
        .i_rdf_valid    (i_rdf_valid),
        .o_owner        (icache_owner)
    );

    read_owner_tracker dcache_tracker_inst (
        .clk            (clk),
        .rst            (rst),
        .i_issue        (read_issued && (i_grant == GRANT_DCACHE)),
        .i_issue_num    (issued_num),
        .i_serviced_num (serviced_num),
        .i_rdf_valid    (i_rdf_valid),
        .o_owner        (dcache_owner)
    );

    // pixel feeder is the default reader
    assign o_rdf_rd_en = icache_owner ? i_icache_rd_en :
                         dcache_owner ? i_dcache_rd_en :
                         i_pixel_rd_en;

    assign o_icache_rdf_valid = icache_owner && i_rdf_valid;
    assign o_dcache_rdf_valid = !icache_owner && dcache_owner && i_rdf_valid;
    assign o_pixel_rdf_valid  = !icache_owner && !dcache_owner && i_rdf_valid;

endmodule

// ==== hdl/ddr_request_controller.sv ====
// four clients share the ddr2 fifos; each cache may keep only one read outstanding at a time
`timescale 1ns/1ns

module ddr_request_controller
    import ddr_req_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // client requests
    input  cache_req_t i_icache_req,
    input  cache_req_t i_dcache_req,
    input  rd_req_t    i_pixel_req,
    input  wr_req_t    i_filler_req,
    // client read-data pops
    input  logic       i_icache_rd_en,
    input  logic       i_dcache_rd_en,
    input  logic       i_pixel_rd_en,
    // ddr2 fifo status
    input  fifo_full_t i_fifo_full,
    input  logic       i_rdf_valid,
    // to the ddr2 fifos
    output ddr_req_t   o_ddr_req,
    output logic       o_rdf_rd_en,
    // back to the clients
    output fifo_full_t o_icache_full,
    output fifo_full_t o_dcache_full,
    output fifo_full_t o_pixel_full,
    output fifo_full_t o_filler_full,
    output logic       o_icache_rdf_valid,
    output logic       o_dcache_rdf_valid,
    output logic       o_pixel_rdf_valid
);

    // *********************************************************************
    // write side arbitration
    // *********************************************************************

    grant_e grant;

    req_arbiter req_arbiter_inst (
        .clk           (clk),
        .rst           (rst),
        .i_icache_req  (i_icache_req),
        .i_dcache_req  (i_dcache_req),
        .i_pixel_req   (i_pixel_req),
        .i_filler_req  (i_filler_req),
        .i_fifo_full   (i_fifo_full),
        .o_ddr_req     (o_ddr_req),
        .o_grant       (grant),
        .o_icache_full (o_icache_full),
        .o_dcache_full (o_dcache_full),
        .o_pixel_full  (o_pixel_full),
        .o_filler_full (o_filler_full)
    );

    // *********************************************************************
    // read return steering
    // *********************************************************************

    // router watches the accepted request to number the reads
    read_return_router read_return_router_inst (
        .clk                (clk),
        .rst                (rst),
        .i_grant            (grant),
        .i_ddr_req          (o_ddr_req),
        .i_rdf_valid        (i_rdf_valid),
        .i_icache_rd_en     (i_icache_rd_en),
        .i_dcache_rd_en     (i_dcache_rd_en),
        .i_pixel_rd_en      (i_pixel_rd_en),
        .o_rdf_rd_en        (o_rdf_rd_en),
        .o_icache_rdf_valid (o_icache_rdf_valid),
        .o_dcache_rdf_valid (o_dcache_rdf_valid),
        .o_pixel_rdf_valid  (o_pixel_rdf_valid)
    );

endmodule

// ==== dv/tb_ddr_request_controller.sv ====
// table-driven check of arbitration, reservation and read routing; one read per cache in flight
`timescale 1ns/1ns

module tb_ddr_request_controller
    import ddr_req_pkg::*;
();

    // one table row is one clock of stimulus
    typedef struct packed {
        logic       rst;
        cache_req_t ic;
        cache_req_t dc;
        rd_req_t    px;
        wr_req_t    fl;
        fifo_full_t full;
        logic       valid;
    } row_t;

    logic       clk;
    logic       rst;
    cache_req_t i_icache_req;
    cache_req_t i_dcache_req;
    rd_req_t    i_pixel_req;
    wr_req_t    i_filler_req;
    logic       i_icache_rd_en;
    logic       i_dcache_rd_en;
    logic       i_pixel_rd_en;
    fifo_full_t i_fifo_full;
    logic       i_rdf_valid;
    ddr_req_t   o_ddr_req;
    logic       o_rdf_rd_en;
    fifo_full_t o_icache_full;
    fifo_full_t o_dcache_full;
    fifo_full_t o_pixel_full;
    fifo_full_t o_filler_full;
    logic       o_icache_rdf_valid;
    logic       o_dcache_rdf_valid;
    logic       o_pixel_rdf_valid;

    row_t        rows[$];
    logic [31:0] lfsr_state = 32'hd2a9eb69;
    // reference model state
    logic        model_reserved;
    grant_e      owner_q[$];
    int          beats_seen;

    ddr_request_controller ddr_request_controller_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // *********************************************************************
    // random fields and table rows
    // *********************************************************************

    // galois lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[DATA_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic cache_req_t make_cache(input logic en, input logic [CMD_W-1:0] cmd);
        cache_req_t c;
        logic [DATA_W-1:0] bits;
        bits = rand_bits(ADDR_W);
        c.addr = bits[ADDR_W-1:0];
        c.wdf_data = rand_bits(DATA_W);
        bits = rand_bits(MASK_W);
        c.wdf_mask = bits[MASK_W-1:0];
        c.cmd_en = en;
        c.cmd = cmd;
        // a cache write carries its data beat, a read does not
        c.wdf_en = en && (cmd == CMD_WRITE);
        return c;
    endfunction

    function automatic rd_req_t make_pixel(input logic en);
        rd_req_t p;
        logic [DATA_W-1:0] bits;
        bits = rand_bits(ADDR_W);
        p.addr = bits[ADDR_W-1:0];
        p.cmd_en = en;
        return p;
    endfunction

    function automatic wr_req_t make_filler(input logic en);
        wr_req_t f;
        logic [DATA_W-1:0] bits;
        bits = rand_bits(ADDR_W);
        f.addr = bits[ADDR_W-1:0];
        f.wdf_data = rand_bits(DATA_W);
        bits = rand_bits(MASK_W);
        f.wdf_mask = bits[MASK_W-1:0];
        f.cmd_en = en;
        f.wdf_en = en;
        return f;
    endfunction

    task automatic add_row(input cache_req_t ic, input cache_req_t dc, input rd_req_t px,
                           input wr_req_t fl, input fifo_full_t full, input logic valid);
        rows.push_back({1'b0, ic, dc, px, fl, full, valid});
    endtask

    task automatic add_idle(input logic valid);
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                make_filler(1'b0), 2'b00, valid);
    endtask

    // three cycles of reset with nobody requesting
    task automatic add_reset();
        row_t r;
        repeat (3) begin
            r = '0;
            r.rst = 1'b1;
            rows.push_back(r);
        end
    endtask

    task automatic build_table();
        add_reset();
        // stray beat right after reset belongs to the pixel feeder
        add_idle(1'b1);
        add_idle(1'b0);
        add_reset();
        // each winner drops out in turn; the filler's beat opens its burst
        add_row(make_cache(1'b1, CMD_WRITE), make_cache(1'b1, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b1), 2'b00, 1'b0);
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b1, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b1), 2'b00, 1'b0);
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b1), 2'b00, 1'b0);
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                make_filler(1'b1), 2'b00, 1'b0);
        // icache locked out for the second filler beat, then wins
        repeat (2) begin
            add_row(make_cache(1'b1, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                    make_filler(1'b1), 2'b00, 1'b0);
        end
        // back-pressure from either fifo, then both
        add_row(make_cache(1'b1, CMD_WRITE), make_cache(1'b1, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b1), 2'b10, 1'b0);
        add_row(make_cache(1'b1, CMD_WRITE), make_cache(1'b1, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b1), 2'b01, 1'b0);
        add_row(make_cache(1'b1, CMD_READ), make_cache(1'b1, CMD_READ), make_pixel(1'b1),
                make_filler(1'b1), 2'b11, 1'b0);
        // pixel granted but held off so no read may be counted
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b0), 2'b10, 1'b0);
        // reservation survives a full fifo
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                make_filler(1'b1), 2'b00, 1'b0);
        add_row(make_cache(1'b1, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                make_filler(1'b1), 2'b01, 1'b0);
        add_row(make_cache(1'b1, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                make_filler(1'b1), 2'b00, 1'b0);
        // pixel read command, then a filler burst on its own
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b0), 2'b00, 1'b0);
        repeat (2) begin
            add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                    make_filler(1'b1), 2'b00, 1'b0);
        end
        // two pixel reads are pending here
        repeat (4) add_idle(1'b1);
        // icache, dcache and pixel reads, then six returned beats with gaps
        add_row(make_cache(1'b1, CMD_READ), make_cache(1'b0, CMD_WRITE), make_pixel(1'b0),
                make_filler(1'b0), 2'b00, 1'b0);
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b1, CMD_READ), make_pixel(1'b0),
                make_filler(1'b0), 2'b00, 1'b0);
        add_row(make_cache(1'b0, CMD_WRITE), make_cache(1'b0, CMD_WRITE), make_pixel(1'b1),
                make_filler(1'b0), 2'b00, 1'b0);
        repeat (3) begin
            add_idle(1'b0);
            add_idle(1'b1);
            add_idle(1'b1);
        end
        add_idle(1'b0);
    endtask

    // *********************************************************************
    // reference model
    // *********************************************************************

    function automatic grant_e pick_grant(input row_t r);
        logic fl;
        fl = r.fl.cmd_en || r.fl.wdf_en;
        if (model_reserved) begin
            return fl ? GRANT_FILLER : GRANT_NONE;
        end
        if (r.ic.cmd_en || r.ic.wdf_en) begin
            return GRANT_ICACHE;
        end
        if (r.dc.cmd_en || r.dc.wdf_en) begin
            return GRANT_DCACHE;
        end
        if (r.px.cmd_en) begin
            return GRANT_PIXEL;
        end
        return fl ? GRANT_FILLER : GRANT_NONE;
    endfunction

    function automatic ddr_req_t expected_req(input row_t r, input grant_e g, input logic busy);
        ddr_req_t e;
        e = '0;
        case (g)
            GRANT_ICACHE: e = ddr_req_t'(r.ic);
            GRANT_DCACHE: e = ddr_req_t'(r.dc);
            GRANT_PIXEL: begin
                e.cmd_en   = r.px.cmd_en;
                e.cmd      = CMD_READ;
                e.addr     = r.px.addr;
                e.wdf_mask = MASK_NONE;
            end
            GRANT_FILLER: begin
                e.cmd_en   = r.fl.cmd_en;
                e.cmd      = CMD_WRITE;
                e.addr     = r.fl.addr;
                e.wdf_en   = r.fl.wdf_en;
                e.wdf_data = r.fl.wdf_data;
                e.wdf_mask = r.fl.wdf_mask;
            end
            default: e = '0;
        endcase
        // nothing enters while either fifo is full
        e.cmd_en = e.cmd_en && !busy;
        e.wdf_en = e.wdf_en && !busy;
        return e;
    endfunction

    function automatic fifo_full_t client_full(input logic granted, input logic busy);
        fifo_full_t f;
        f.cmd_full = !granted || busy;
        f.wdf_full = !granted || busy;
        return f;
    endfunction

    // *********************************************************************
    // compare tasks
    // *********************************************************************

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopping at the first failed check");
    endtask

    // payload fields only count while some client holds the grant
    task automatic check_ddr_req(input string name, input ddr_req_t act, input ddr_req_t exp,
                                 input logic payload);
        if (payload ? (act !== exp)
                    : ({act.cmd_en, act.wdf_en} !== {exp.cmd_en, exp.wdf_en})) begin
            $display("ERROR: %s actual 0x%h expected 0x%h", name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_full(input string name, input fifo_full_t act, input fifo_full_t exp);
        if (act !== exp) begin
            $display("ERROR: %s actual 0x%h expected 0x%h", name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERROR: %s actual 0x%h expected 0x%h", name, act, exp);
            abort_run();
        end
    endtask

    // compare one cycle, then advance the model to the next edge
    task automatic check_step(input row_t r, input logic [2:0] rd);
        logic     busy;
        grant_e   g;
        grant_e   owner;
        ddr_req_t exp;
        busy = r.full.cmd_full || r.full.wdf_full;
        g = pick_grant(r);
        exp = expected_req(r, g, busy);
        owner = (owner_q.size() != 0) ? owner_q[0] : GRANT_PIXEL;
        check_ddr_req("o_ddr_req", o_ddr_req, exp, g != GRANT_NONE);
        check_full("o_icache_full", o_icache_full, client_full(g == GRANT_ICACHE, busy));
        check_full("o_dcache_full", o_dcache_full, client_full(g == GRANT_DCACHE, busy));
        check_full("o_pixel_full", o_pixel_full, client_full(g == GRANT_PIXEL, busy));
        check_full("o_filler_full", o_filler_full, client_full(g == GRANT_FILLER, busy));
        check_bit("o_icache_rdf_valid", o_icache_rdf_valid, r.valid && owner == GRANT_ICACHE);
        check_bit("o_dcache_rdf_valid", o_dcache_rdf_valid, r.valid && owner == GRANT_DCACHE);
        check_bit("o_pixel_rdf_valid", o_pixel_rdf_valid, r.valid && owner == GRANT_PIXEL);
        check_bit("o_rdf_rd_en", o_rdf_rd_en,
                  (owner == GRANT_ICACHE) ? rd[2] : (owner == GRANT_DCACHE) ? rd[1] : rd[0]);
        if (g == GRANT_FILLER && !busy) begin
            model_reserved = !model_reserved;
        end
        // beats of this cycle belong to the reads issued before it
        if (r.valid && owner_q.size() != 0) begin
            beats_seen++;
            if (beats_seen == BEATS_PER_READ) begin
                void'(owner_q.pop_front());
                beats_seen = 0;
            end
        end
        if (exp.cmd_en && exp.cmd == CMD_READ) begin
            owner_q.push_back(g);
        end
    endtask

    // *********************************************************************
    // main sequence
    // *********************************************************************

    initial begin
        logic [DATA_W-1:0] bits;
        logic [2:0]        rd;
        rst            <= 1'b1;
        i_icache_req   <= '0;
        i_dcache_req   <= '0;
        i_pixel_req    <= '0;
        i_filler_req   <= '0;
        i_icache_rd_en <= 1'b0;
        i_dcache_rd_en <= 1'b0;
        i_pixel_rd_en  <= 1'b0;
        i_fifo_full    <= '0;
        i_rdf_valid    <= 1'b0;
        build_table();
        foreach (rows[i]) begin
            bits = rand_bits(3);
            rd = bits[2:0];
            @(posedge clk);
            rst            <= rows[i].rst;
            i_icache_req   <= rows[i].ic;
            i_dcache_req   <= rows[i].dc;
            i_pixel_req    <= rows[i].px;
            i_filler_req   <= rows[i].fl;
            i_fifo_full    <= rows[i].full;
            i_rdf_valid    <= rows[i].valid;
            i_icache_rd_en <= rd[2];
            i_dcache_rd_en <= rd[1];
            i_pixel_rd_en  <= rd[0];
            // outputs are settled half a period after the drive
            @(negedge clk);
            if (rows[i].rst) begin
                model_reserved = 1'b0;
                owner_q.delete();
                beats_seen = 0;
            end else begin
                check_step(rows[i], rd);
            end
        end
        if (owner_q.size() != 0 || beats_seen != 0) begin
            $display("read responses were still owed when the stimulus table ran out");
            abort_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
hdl/ddr_req_pkg.sv
hdl/req_arbiter.sv
hdl/read_owner_tracker.sv
hdl/read_return_router.sv
hdl/ddr_request_controller.sv
dv/tb_ddr_request_controller.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the ddr request controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_ddr_request_controller -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
